/* logic/dcache_pkg.sv */
// cache geometry, address field types and helpers
// request and memory bus structs, miss state encoding
package dcache_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 32;
    localparam int LINE_WORDS   = 4;
    localparam int WAYS         = 2;
    localparam int SETS         = 64;
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * WORD_WIDTH / 8);
    localparam int INDEX_WIDTH  = $clog2(SETS);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [WORD_WIDTH-1:0]            word_t;
    typedef logic [WORD_WIDTH/8-1:0]          strb_t;
    typedef logic [TAG_WIDTH-1:0]             tag_t;
    typedef logic [INDEX_WIDTH-1:0]           index_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]    word_sel_t;
    typedef logic [WAYS-1:0]                  way_t;
    // word 0 in the low bits
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef struct packed {
        logic  rd_req;
        addr_t rd_addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic  wr_req;
        addr_t wr_addr;
        line_t wr_data;
    } mem_wr_req_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } miss_state_t;

    function automatic index_t addr_index(input addr_t addr);
        return addr[OFFSET_WIDTH +: INDEX_WIDTH];
    endfunction

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    endfunction

    function automatic word_sel_t addr_word(input addr_t addr);
        return addr[OFFSET_WIDTH-1 -: $clog2(LINE_WORDS)];
    endfunction

endpackage

/* logic/dcache_tag_store.sv */
// tag, valid and dirty flops per way and set
// one lru bit per set with the victim way
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  dcache_pkg::index_t                     index,
    input  logic                                   refill_we,
    input  dcache_pkg::way_t                       refill_way,
    input  dcache_pkg::tag_t                       refill_tag,
    input  dcache_pkg::way_t                       store_hit,
    output dcache_pkg::tagv_t [dcache_pkg::WAYS-1:0] tagv,
    output dcache_pkg::way_t                       dirty,
    output dcache_pkg::way_t                       victim,
    input  dcache_pkg::way_t                       lru_touch
);
    import dcache_pkg::*;

    tag_t                       tag_q [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid_q;
    logic [WAYS-1:0][SETS-1:0]  dirty_q;
    // way used most recently in each set
    logic [SETS-1:0]            mru_q;

    // tags carry no reset, valid bits qualify them
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (refill_we && refill_way[w]) begin
                tag_q[w][index] <= refill_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (refill_we && refill_way[w]) begin
                    valid_q[w][index] <= 1'b1;
                    dirty_q[w][index] <= 1'b0;
                end else if (store_hit[w]) begin
                    dirty_q[w][index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mru_q <= '0;
        end else if (lru_touch[1]) begin
            mru_q[index] <= 1'b1;
        end else if (lru_touch[0]) begin
            mru_q[index] <= 1'b0;
        end
    end

    // combinational read at the request index
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            tagv[w].valid = valid_q[w][index];
            tagv[w].tag   = tag_q[w][index];
            dirty[w]      = dirty_q[w][index];
        end
    end

    // two ways, so the victim is simply the other one
    assign victim = mru_q[index] ? 2'b01 : 2'b10;

endmodule

/* logic/dcache_data_array.sv */
// line storage per way with refill and store writes
// one-entry store buffer and the load bypass out of it
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                 clk,
    input  logic                 arst_n,
    input  dcache_pkg::index_t   rd_index,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::way_t     hit,
    input  logic                 refill_we,
    input  dcache_pkg::way_t     refill_way,
    input  dcache_pkg::line_t    refill_line,
    output dcache_pkg::word_t    hit_word,
    output dcache_pkg::line_t    victim_line,
    input  dcache_pkg::way_t     victim_way
);
    import dcache_pkg::*;

    typedef struct packed {
        logic      valid;
        way_t      way;
        index_t    index;
        word_sel_t sel;
        word_t     data;
    } store_buf_t;

    word_t      mem [WAYS][SETS][LINE_WORDS];
    index_t     rd_index_q;
    line_t      way_line [WAYS];
    word_t      array_word;
    word_t      merged;
    store_buf_t sb_q;
    logic       sb_match;
    logic       store_hit;

    assign store_hit = req.write && (|hit);

    // registered read address, the buffered store lands one cycle late
    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
        for (int w = 0; w < WAYS; w++) begin
            if (sb_q.valid && sb_q.way[w]) begin
                mem[w][sb_q.index][sb_q.sel] <= sb_q.data;
            end
            if (refill_we && refill_way[w]) begin
                for (int k = 0; k < LINE_WORDS; k++) begin
                    mem[w][addr_index(req.addr)][k] <= refill_line[k*WORD_WIDTH +: WORD_WIDTH];
                end
            end
        end
    end

    always_comb begin
        array_word  = '0;
        victim_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                way_line[w][k*WORD_WIDTH +: WORD_WIDTH] = mem[w][rd_index_q][k];
            end
            if (hit[w]) begin
                array_word = array_word | way_line[w][addr_word(req.addr)*WORD_WIDTH +: WORD_WIDTH];
            end
            if (victim_way[w]) begin
                victim_line = victim_line | way_line[w];
            end
        end
    end

    // word still parked in the buffer wins over the array
    assign sb_match = sb_q.valid && (sb_q.way == hit) && (sb_q.index == addr_index(req.addr))
                      && (sb_q.sel == addr_word(req.addr));
    assign hit_word = sb_match ? sb_q.data : array_word;

    always_comb begin
        merged = hit_word;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (req.strb[b]) begin
                merged[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sb_q <= '0;
        end else if (store_hit) begin
            sb_q.valid <= 1'b1;
            sb_q.way   <= hit;
            sb_q.index <= addr_index(req.addr);
            sb_q.sel   <= addr_word(req.addr);
            sb_q.data  <= merged;
        end else begin
            sb_q.valid <= 1'b0;
        end
    end

endmodule

/* logic/dcache_miss_fsm.sv */
// miss engine: dirty victim writeback, then line refill
`timescale 1ns/1ps

module dcache_miss_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  dcache_pkg::cpu_req_t    req,
    input  dcache_pkg::way_t        hit,
    input  dcache_pkg::way_t        victim,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        victim_tag,
    input  dcache_pkg::line_t       victim_line,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    wr_rdy,
    input  logic                    wr_valid,
    output dcache_pkg::mem_rd_req_t mem_rd,
    output dcache_pkg::mem_wr_req_t mem_wr,
    output logic                    refill_we,
    output logic                    miss_busy
);
    import dcache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;
    logic        miss;
    logic        wb_needed;

    assign miss      = req.valid && (hit == '0);
    // dirty bit of the victim way decides the writeback
    assign wb_needed = victim_dirty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (miss) begin
                    state_d = wb_needed ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (wr_rdy) begin
                    state_d = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (wr_valid) begin
                    state_d = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (rd_rdy) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_d = REFILL_DONE;
                end
            end
            REFILL_DONE: begin
                state_d = LOOKUP;
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    // line-aligned addresses on both channels
    assign mem_rd.rd_req  = (state_q == MISS_CLEAN);
    assign mem_rd.rd_addr = {req.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign mem_wr.wr_req  = (state_q == MISS_DIRTY);
    assign mem_wr.wr_addr = {victim_tag, addr_index(req.addr), {OFFSET_WIDTH{1'b0}}};
    assign mem_wr.wr_data = victim_line;

    assign refill_we = (state_q == REFILL) && ret_valid;

    // the lookup cycle of a miss is already busy
    assign miss_busy = (state_q != LOOKUP) || miss;

endmodule

/* logic/dcache_top.sv */
// data cache top: request register, hit detection, read-data mux
// and the tag store, data array and miss engine instances
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output logic                    busy,
    output dcache_pkg::word_t       rdata,
    output dcache_pkg::mem_rd_req_t mem_rd,
    output dcache_pkg::mem_wr_req_t mem_wr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  dcache_pkg::line_t       ret_data,
    input  logic                    wr_rdy,
    input  logic                    wr_valid
);
    import dcache_pkg::*;

    cpu_req_t         req_q;
    index_t           req_index;
    tag_t             req_tag;
    index_t           rd_index;
    tagv_t [WAYS-1:0] tagv;
    way_t             dirty;
    way_t             victim;
    way_t             hit;
    way_t             store_hit;
    logic             victim_dirty;
    tag_t             victim_tag;
    line_t            victim_line;
    word_t            hit_word;
    logic             refill_we;
    logic             miss_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= '0;
        end else if (!busy) begin
            req_q <= cpu_req;
        end
    end

    assign req_index = addr_index(req_q.addr);
    assign req_tag   = addr_tag(req_q.addr);

    // data read runs one cycle ahead while requests are accepted
    assign rd_index = busy ? req_index : addr_index(cpu_req.addr);

    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = req_q.valid && tagv[w].valid && (tagv[w].tag == req_tag);
            if (victim[w]) begin
                victim_tag = victim_tag | tagv[w].tag;
            end
        end
    end

    assign store_hit    = hit & {WAYS{req_q.write}};
    assign victim_dirty = |(dirty & victim);

    assign busy  = miss_busy;
    assign rdata = (req_q.valid && !req_q.write) ? hit_word : '0;

    dcache_tag_store tag_store_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (req_index),
        .refill_we  (refill_we),
        .refill_way (victim),
        .refill_tag (req_tag),
        .store_hit  (store_hit),
        .tagv       (tagv),
        .dirty      (dirty),
        .victim     (victim),
        .lru_touch  (hit)
    );

    dcache_data_array data_array_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_index    (rd_index),
        .req         (req_q),
        .hit         (hit),
        .refill_we   (refill_we),
        .refill_way  (victim),
        .refill_line (ret_data),
        .hit_word    (hit_word),
        .victim_line (victim_line),
        .victim_way  (victim)
    );

    dcache_miss_fsm miss_fsm_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req_q),
        .hit          (hit),
        .victim       (victim),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .wr_rdy       (wr_rdy),
        .wr_valid     (wr_valid),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .refill_we    (refill_we),
        .miss_busy    (miss_busy)
    );

endmodule

/* dv/dcache_checker.sv */
// memory bus protocol and reset state assertions, bound into the cache top
`timescale 1ns/1ps

module dcache_checker (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    busy,
    input dcache_pkg::mem_rd_req_t mem_rd,
    input dcache_pkg::mem_wr_req_t mem_wr,
    input logic                    rd_rdy,
    input logic                    wr_rdy
);
    int fail_count = 0;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_rd.rd_req && mem_wr.wr_req))
        else begin
            $error("read and write requests high in the same cycle");
            fail_count++;
        end

    // request held until the ready strobe
    rd_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rd.rd_req && !rd_rdy |=> mem_rd.rd_req)
        else begin
            $error("rd_req dropped before rd_rdy");
            fail_count++;
        end

    wr_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr.wr_req && !wr_rdy |=> mem_wr.wr_req)
        else begin
            $error("wr_req dropped before wr_rdy");
            fail_count++;
        end

    busy_low_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
        else begin
            $error("busy high in the first cycle after reset");
            fail_count++;
        end

endmodule

/* dv/dcache_tb.sv */
// data cache testbench: clock, reset, memory responder and flat memory model
// directed hit, bypass and eviction checks, then a random load/store mix
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_DIRECTED = 10;
    localparam int N_RANDOM   = 500;
    localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 20;
    localparam int MEM_WORDS  = 1024;

    // request captured by the DUT, still waiting for its result
    typedef struct packed {
        logic  valid;
        logic  load;
        logic  hit;
        addr_t addr;
        word_t exp;
    } pending_t;

    logic        clk;
    logic        arst_n;
    cpu_req_t    cpu_req;
    logic        busy;
    word_t       rdata;
    mem_rd_req_t mem_rd;
    mem_wr_req_t mem_wr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic        wr_rdy;
    logic        wr_valid;

    // expected contents in program order, and what memory really holds
    word_t    model_mem [MEM_WORDS];
    word_t    mem_image [MEM_WORDS];
    pending_t pend;
    int       seed = 31930;
    int       err_count = 0;
    int       cycle_count = 0;
    int       rd_count = 0;
    int       wr_count = 0;
    int       event_seq = 0;
    int       last_rd_seq;
    int       last_wr_seq;
    addr_t    last_rd_addr;
    addr_t    last_wr_addr;

    dcache_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .busy      (busy),
        .rdata     (rdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_rdy    (wr_rdy),
        .wr_valid  (wr_valid)
    );

    bind dcache_top dcache_checker chk_i (
        .clk    (clk),
        .arst_n (arst_n),
        .busy   (busy),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr),
        .rd_rdy (rd_rdy),
        .wr_rdy (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f1e;
    endfunction

    function automatic int word_idx(input addr_t a);
        return int'(a[11:2]);
    endfunction

    // four tags, four sets, four words
    function automatic addr_t pool_addr(input int tag_sel, input int set_sel, input int word_sel);
        return addr_t'((tag_sel << 10) | (set_sel << OFFSET_WIDTH) | (word_sel << 2));
    endfunction

    function automatic cpu_req_t make_req(input logic write, input addr_t addr,
                                          input strb_t strb, input word_t wdata);
        cpu_req_t r;
        r.valid = 1'b1;
        r.write = write;
        r.addr  = addr;
        r.wdata = wdata;
        r.strb  = strb;
        return r;
    endfunction

    task automatic skip_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // present a request, check the previous one when busy falls
    task automatic step(input cpu_req_t req, input logic expect_hit);
        int waits;
        int idx;
        waits = 0;
        cpu_req = req;
        @(negedge clk);
        while (busy) begin
            waits++;
            @(negedge clk);
        end
        if (pend.valid && pend.hit) begin
            assert (waits == 0) else fail_run("a request to a resident line waited on a miss");
        end
        if (pend.valid && pend.load) begin
            assert (rdata == pend.exp)
            else fail_run($sformatf("mismatch at %0t ns: load from %h returned %h, expected %h",
                                    $time, pend.addr, rdata, pend.exp));
        end
        idx = word_idx(req.addr);
        pend.valid = req.valid;
        pend.load  = !req.write;
        pend.hit   = expect_hit;
        pend.addr  = req.addr;
        pend.exp   = model_mem[idx];
        if (req.valid && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    model_mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic serve_read();
        int    rdy_delay;
        int    ack_delay;
        addr_t base;
        rdy_delay = $unsigned($random(seed)) % 4;
        ack_delay = 1 + $unsigned($random(seed)) % 4;
        base = mem_rd.rd_addr;
        assert (base[3:0] == 4'h0) else fail_run("refill read address is not line aligned");
        rd_count++;
        event_seq++;
        last_rd_seq  = event_seq;
        last_rd_addr = base;
        @(posedge clk);
        #2;
        skip_cycles(rdy_delay);
        rd_rdy = 1'b1;
        skip_cycles(1);
        rd_rdy = 1'b0;
        skip_cycles(ack_delay - 1);
        for (int k = 0; k < LINE_WORDS; k++) begin
            ret_data[k*WORD_WIDTH +: WORD_WIDTH] = mem_image[word_idx(base) + k];
        end
        ret_valid = 1'b1;
        skip_cycles(1);
        ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        int    rdy_delay;
        int    ack_delay;
        addr_t base;
        word_t got;
        rdy_delay = $unsigned($random(seed)) % 4;
        ack_delay = 1 + $unsigned($random(seed)) % 4;
        base = mem_wr.wr_addr;
        assert (base[3:0] == 4'h0) else fail_run("writeback address is not line aligned");
        for (int k = 0; k < LINE_WORDS; k++) begin
            got = mem_wr.wr_data[k*WORD_WIDTH +: WORD_WIDTH];
            assert (got == model_mem[word_idx(base) + k])
            else fail_run($sformatf("mismatch at %0t ns: writeback word %0d of %h is %h, expected %h",
                                    $time, k, base, got, model_mem[word_idx(base) + k]));
            mem_image[word_idx(base) + k] = got;
        end
        wr_count++;
        event_seq++;
        last_wr_seq  = event_seq;
        last_wr_addr = base;
        @(posedge clk);
        #2;
        skip_cycles(rdy_delay);
        wr_rdy = 1'b1;
        skip_cycles(1);
        wr_rdy = 1'b0;
        skip_cycles(ack_delay - 1);
        wr_valid = 1'b1;
        skip_cycles(1);
        wr_valid = 1'b0;
    endtask

    // memory responder, one transfer at a time
    initial begin
        forever begin
            @(negedge clk);
            if (mem_wr.wr_req) begin
                serve_write();
            end else if (mem_rd.rd_req) begin
                serve_read();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < MAX_CYCLES)
        else fail_run($sformatf("timeout: tests still running after %0d cycles", MAX_CYCLES));
        assert (dut_i.chk_i.fail_count == 0)
        else fail_run("a protocol assertion in the bound checker failed");
    end

    initial begin
        logic  wr_bit;
        int    tag_sel;
        int    set_sel;
        int    word_sel;
        strb_t strb;
        word_t wdata;
        arst_n    = 1'b0;
        cpu_req   = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_valid  = 1'b0;
        pend      = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(addr_t'(i * 4));
            mem_image[i] = model_mem[i];
        end
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!busy && !mem_rd.rd_req && !mem_wr.wr_req)
        else fail_run("busy or a memory request is high after reset");
        @(posedge clk);
        #2;

        // cold miss, then a hit in the same line
        step(make_req(1'b0, pool_addr(0, 1, 0), '0, '0), 1'b0);
        step(make_req(1'b0, pool_addr(0, 1, 2), '0, '0), 1'b1);
        assert (rd_count == 1 && wr_count == 0 && last_rd_addr == pool_addr(0, 1, 0))
        else fail_run("first load did not issue exactly one refill read of its line");

        // store and an immediate load of the same word
        step(make_req(1'b1, pool_addr(0, 1, 2), 4'b0101, 32'hdead_beef), 1'b1);
        step(make_req(1'b0, pool_addr(0, 1, 2), '0, '0), 1'b1);

        // second line made dirty, a third line then evicts the first
        step(make_req(1'b0, pool_addr(1, 1, 0), '0, '0), 1'b0);
        step(make_req(1'b1, pool_addr(1, 1, 1), 4'b1111, 32'h1234_5678), 1'b1);
        step(make_req(1'b0, pool_addr(2, 1, 3), '0, '0), 1'b0);
        step('0, 1'b0);
        assert (wr_count == 1 && last_wr_addr == pool_addr(0, 1, 0))
        else fail_run("eviction of the dirty line did not write it back");
        assert (last_wr_seq < last_rd_seq && last_rd_addr == pool_addr(2, 1, 0))
        else fail_run("writeback did not come before the refill of the new line");

        for (int i = 0; i < N_RANDOM; i++) begin
            wr_bit   = $unsigned($random(seed)) % 2;
            tag_sel  = $unsigned($random(seed)) % 4;
            set_sel  = $unsigned($random(seed)) % 4;
            word_sel = $unsigned($random(seed)) % 4;
            strb     = $random(seed);
            wdata    = $random(seed);
            step(make_req(wr_bit, pool_addr(tag_sel, set_sel, word_sel), strb, wdata), 1'b0);
        end
        step('0, 1'b0);

        if (err_count == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_array.sv
logic/dcache_miss_fsm.sv
logic/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/dcache_tag_store.sv
  - logic/dcache_data_array.sv
  - logic/dcache_miss_fsm.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv
